// File: Makefile
# Verilator flow for the DDR3 command path
VERILATOR ?= verilator
TOP       ?= tb_ddr3_cmd
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv) $(wildcard tb/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run passes only when the pass message shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
src/ddr3_cmd_pkg.sv
src/ddr3_geom_pkg.sv
src/ddr3_req_if.sv
src/ddr3_sel_if.sv
src/ddr3_req_decode.sv
src/ddr3_fsm.sv
src/ddr3_resp_gen.sv
src/ddr3_cmd_top.sv
tb/tb_clock.sv
tb/ddr3_dfi_model.sv
tb/tb_ddr3_cmd.sv

// File: src/ddr3_cmd_pkg.sv
package ddr3_cmd_pkg;

  // ddr3 command codes, bit order is {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    // mode-register set
    CMD_MODE = 3'b000,
    CMD_REFR = 3'b001,
    // single-bank close when a10 is low
    CMD_PREC = 3'b010,
    CMD_ACTV = 3'b011,
    CMD_WRIT = 3'b100,
    CMD_READ = 3'b101,
    // zq calibration, only forwarded while in reset
    CMD_ZQCL = 3'b110,
    CMD_NOOP = 3'b111
  } ddr3_cmd_t;

  // execute-stage states
  typedef enum logic [2:0] {
    ST_IDLE = 3'd0,
    // activate presented, waiting for the data layer
    ST_ACTV = 3'd1,
    // column bursts, one read or write per beat
    ST_COL  = 3'd2,
    // closing the bank after a broken burst
    ST_PREC = 3'd3,
    ST_REFR = 3'd4
  } ddr3_state_t;

endpackage

// File: src/ddr3_cmd_top.sv
`timescale 1ns/1ps

module ddr3_cmd_top #(
  parameter int DDR_ROW_BITS = ddr3_geom_pkg::DEF_ROW_BITS,
  parameter int DDR_COL_BITS = ddr3_geom_pkg::DEF_COL_BITS,
  parameter int REQID = ddr3_geom_pkg::DEF_REQID
) (
  input  logic                                clock,
  input  logic                                reset,
  // write port
  input  logic                                mem_wrreq_i,
  input  logic                                mem_wrlst_i,
  input  logic [REQID-1:0]                    mem_wrtid_i,
  input  logic [ddr3_geom_pkg::addr_bits(DDR_ROW_BITS, DDR_COL_BITS)-1:0] mem_wradr_i,
  output logic                                mem_wrack_o,
  output logic                                mem_wrerr_o,
  output logic [REQID-1:0]                    mem_wrtid_o,
  // read port
  input  logic                                mem_rdreq_i,
  input  logic                                mem_rdlst_i,
  input  logic [REQID-1:0]                    mem_rdtid_i,
  input  logic [ddr3_geom_pkg::addr_bits(DDR_ROW_BITS, DDR_COL_BITS)-1:0] mem_rdadr_i,
  output logic                                mem_rdack_o,
  output logic                                mem_rderr_o,
  output logic [REQID-1:0]                    mem_rdtid_o,
  // configuration port, live only in reset
  input  logic                                cfg_req_i,
  output logic                                cfg_rdy_o,
  input  ddr3_cmd_pkg::ddr3_cmd_t             cfg_cmd_i,
  input  logic [ddr3_geom_pkg::BANK_BITS-1:0] cfg_ba_i,
  input  logic [DDR_ROW_BITS-1:0]             cfg_adr_i,
  // dfi data layer
  output logic                                ddl_req_o,
  output logic                                ddl_seq_o,
  output ddr3_cmd_pkg::ddr3_cmd_t             ddl_cmd_o,
  output logic [ddr3_geom_pkg::BANK_BITS-1:0] ddl_ba_o,
  output logic [DDR_ROW_BITS-1:0]             ddl_adr_o,
  input  logic                                ddl_rdy_i,
  input  logic                                ddl_ref_i
);
  import ddr3_geom_pkg::*;

  localparam int ADDR_W = addr_bits(DDR_ROW_BITS, DDR_COL_BITS);

  logic             busy_w;
  logic             beat_w;
  logic             beat_rd_w;
  logic [REQID-1:0] beat_tid_w;
  logic             brk_w;

  ddr3_req_if #(.REQID(REQID), .ADDRS(ADDR_W)) wr_bus ();
  ddr3_req_if #(.REQID(REQID), .ADDRS(ADDR_W)) rd_bus ();
  ddr3_sel_if #(
    .DDR_ROW_BITS(DDR_ROW_BITS),
    .DDR_COL_BITS(DDR_COL_BITS),
    .REQID(REQID)
  ) sel_bus ();

  assign wr_bus.req  = mem_wrreq_i;
  assign wr_bus.lst  = mem_wrlst_i;
  assign wr_bus.tid  = mem_wrtid_i;
  assign wr_bus.adr  = mem_wradr_i;
  assign mem_wrack_o = wr_bus.ack;
  assign mem_wrerr_o = wr_bus.err;

  assign rd_bus.req  = mem_rdreq_i;
  assign rd_bus.lst  = mem_rdlst_i;
  assign rd_bus.tid  = mem_rdtid_i;
  assign rd_bus.adr  = mem_rdadr_i;
  assign mem_rdack_o = rd_bus.ack;
  assign mem_rderr_o = rd_bus.err;

  // config source sees the data layer's ready directly
  assign cfg_rdy_o = ddl_rdy_i;

  ddr3_req_decode #(
    .DDR_ROW_BITS(DDR_ROW_BITS),
    .DDR_COL_BITS(DDR_COL_BITS),
    .REQID(REQID)
  ) u_decode (
    .clock_i(clock),
    .reset_i(reset),
    .rd_port(rd_bus),
    .wr_port(wr_bus),
    .busy_i (busy_w),
    .sel    (sel_bus)
  );

  ddr3_fsm #(
    .DDR_ROW_BITS(DDR_ROW_BITS),
    .DDR_COL_BITS(DDR_COL_BITS),
    .REQID(REQID)
  ) u_fsm (
    .clock     (clock),
    .reset     (reset),
    .cfg_req_i (cfg_req_i),
    .cfg_cmd_i (cfg_cmd_i),
    .cfg_ba_i  (cfg_ba_i),
    .cfg_adr_i (cfg_adr_i),
    .sel       (sel_bus),
    .busy_o    (busy_w),
    .beat_o    (beat_w),
    .beat_rd_o (beat_rd_w),
    .beat_tid_o(beat_tid_w),
    .brk_o     (brk_w),
    .ddl_req_o (ddl_req_o),
    .ddl_seq_o (ddl_seq_o),
    .ddl_cmd_o (ddl_cmd_o),
    .ddl_ba_o  (ddl_ba_o),
    .ddl_adr_o (ddl_adr_o),
    .ddl_rdy_i (ddl_rdy_i),
    .ddl_ref_i (ddl_ref_i)
  );

  ddr3_resp_gen #(.REQID(REQID)) u_resp (
    .clock     (clock),
    .reset     (reset),
    .beat_i    (beat_w),
    .beat_rd_i (beat_rd_w),
    .beat_tid_i(beat_tid_w),
    .brk_i     (brk_w),
    .rd_port   (rd_bus),
    .wr_port   (wr_bus),
    .rd_tid_o  (mem_rdtid_o),
    .wr_tid_o  (mem_wrtid_o)
  );

endmodule

// File: src/ddr3_fsm.sv
`timescale 1ns/1ps

module ddr3_fsm #(
  parameter int DDR_ROW_BITS = ddr3_geom_pkg::DEF_ROW_BITS,
  parameter int DDR_COL_BITS = ddr3_geom_pkg::DEF_COL_BITS,
  parameter int REQID = ddr3_geom_pkg::DEF_REQID
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                cfg_req_i,
  input  ddr3_cmd_pkg::ddr3_cmd_t             cfg_cmd_i,
  input  logic [ddr3_geom_pkg::BANK_BITS-1:0] cfg_ba_i,
  input  logic [DDR_ROW_BITS-1:0]             cfg_adr_i,
  ddr3_sel_if.dst                             sel,
  output logic                                busy_o,
  output logic                                beat_o,
  output logic                                beat_rd_o,
  output logic [REQID-1:0]                    beat_tid_o,
  output logic                                brk_o,
  output logic                                ddl_req_o,
  output logic                                ddl_seq_o,
  output ddr3_cmd_pkg::ddr3_cmd_t             ddl_cmd_o,
  output logic [ddr3_geom_pkg::BANK_BITS-1:0] ddl_ba_o,
  output logic [DDR_ROW_BITS-1:0]             ddl_adr_o,
  input  logic                                ddl_rdy_i,
  input  logic                                ddl_ref_i
);
  import ddr3_cmd_pkg::*;
  import ddr3_geom_pkg::*;

  ddr3_state_t             state_q;

  // presented command
  logic                    req_q;
  logic                    seq_q;
  ddr3_cmd_t               cmd_q;
  logic [BANK_BITS-1:0]    ba_q;
  logic [DDR_ROW_BITS-1:0] adr_q;

  // first column command staged while activate is out
  ddr3_cmd_t               cmd_x;
  logic                    seq_x;
  logic [DDR_ROW_BITS-1:0] adr_x;

  logic                    is_rd_q;
  // cycles since the last take
  logic [1:0]              gap_q;
  logic                    take_q;
  logic                    beat_q;
  logic                    brk_q;
  logic [REQID-1:0]        tid_q;

  logic                    stall_w;
  ddr3_cmd_t               col_cmd_w;
  logic [DDR_ROW_BITS-1:0] col_adr_w;

  // data layer holding off a presented command
  assign stall_w = req_q & ~ddl_rdy_i;

  // column address is {colhi, burst zeros} with a10 flagging auto-precharge
  always_comb begin
    col_adr_w = '0;
    col_adr_w[DDR_COL_BITS-1:BURST_BITS] = sel.colhi;
    col_adr_w[AP_BIT] = sel.lst;
  end

  assign col_cmd_w = sel.is_rd ? CMD_READ : CMD_WRIT;

  always_ff @(posedge clock) begin
    take_q <= 1'b0;
    beat_q <= 1'b0;
    brk_q  <= 1'b0;
    if (reset) begin
      // config commands pass straight through while in reset
      state_q <= ST_IDLE;
      req_q   <= cfg_req_i;
      seq_q   <= 1'b0;
      cmd_q   <= cfg_cmd_i;
      ba_q    <= cfg_ba_i;
      adr_q   <= cfg_adr_i;
      is_rd_q <= 1'b0;
      gap_q   <= '0;
    end else if (!stall_w) begin
      case (state_q)
        ST_IDLE: begin
          seq_q <= 1'b0;
          if (ddl_ref_i) begin
            // refresh ahead of any request
            req_q   <= 1'b1;
            cmd_q   <= CMD_REFR;
            ba_q    <= '0;
            adr_q   <= '0;
            state_q <= ST_REFR;
          end else if (sel.valid) begin
            req_q   <= 1'b1;
            seq_q   <= 1'b1;
            cmd_q   <= CMD_ACTV;
            ba_q    <= sel.bank;
            adr_q   <= sel.row;
            cmd_x   <= col_cmd_w;
            seq_x   <= ~sel.lst;
            adr_x   <= col_adr_w;
            is_rd_q <= sel.is_rd;
            state_q <= ST_ACTV;
          end else begin
            req_q <= 1'b0;
            cmd_q <= CMD_NOOP;
          end
        end

        ST_ACTV: begin
          // activate accepted so the staged column command goes out next
          req_q   <= 1'b1;
          seq_q   <= seq_x;
          cmd_q   <= cmd_x;
          adr_q   <= adr_x;
          state_q <= ST_COL;
        end

        ST_COL: begin
          if (req_q) begin
            // beat accepted
            take_q <= 1'b1;
            beat_q <= 1'b1;
            tid_q  <= sel.tid;
            req_q  <= 1'b0;
            cmd_q  <= CMD_NOOP;
            gap_q  <= '0;
            if (!seq_q) begin
              state_q <= ST_IDLE;
            end
          end else if (gap_q != 2'd2) begin
            gap_q <= gap_q + 2'd1;
          end else if (sel.valid) begin
            req_q <= 1'b1;
            seq_q <= ~sel.lst;
            cmd_q <= col_cmd_w;
            adr_q <= col_adr_w;
          end else begin
            // requester gave up mid-burst so the bank is closed
            brk_q   <= 1'b1;
            req_q   <= 1'b1;
            seq_q   <= 1'b0;
            cmd_q   <= CMD_PREC;
            adr_q   <= '0;
            state_q <= ST_PREC;
          end
        end

        ST_PREC: begin
          req_q   <= 1'b0;
          cmd_q   <= CMD_NOOP;
          state_q <= ST_IDLE;
        end

        ST_REFR: begin
          // hold requests off until the data layer drops its refresh request
          if (req_q) begin
            req_q <= 1'b0;
            cmd_q <= CMD_NOOP;
          end else if (!ddl_ref_i) begin
            state_q <= ST_IDLE;
          end
        end

        default: begin
          req_q   <= 1'b0;
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign sel.take   = take_q;
  // a bank is open from activate until the burst ends
  assign busy_o     = state_q inside {ST_ACTV, ST_COL, ST_PREC};
  assign beat_o     = beat_q;
  assign beat_rd_o  = is_rd_q;
  assign beat_tid_o = tid_q;
  assign brk_o      = brk_q;

  assign ddl_req_o  = req_q;
  assign ddl_seq_o  = seq_q;
  assign ddl_cmd_o  = cmd_q;
  assign ddl_ba_o   = ba_q;
  assign ddl_adr_o  = adr_q;

endmodule

// File: src/ddr3_geom_pkg.sv
package ddr3_geom_pkg;

  // defaults match a 1Gb x16 part
  localparam int DEF_ROW_BITS = 13;
  localparam int DEF_COL_BITS = 10;
  localparam int BANK_BITS = 3;
  // low column bits, always zero since requests are burst-aligned
  localparam int BURST_BITS = 3;
  localparam int DEF_REQID = 4;
  // auto-precharge flag on column commands
  localparam int AP_BIT = 10;

  // request address layout is {row, bank, colhi}, colhi at bit 0
  function automatic int bank_lsb(int col_bits);
    return col_bits - BURST_BITS;
  endfunction

  function automatic int row_lsb(int col_bits);
    return bank_lsb(col_bits) + BANK_BITS;
  endfunction

  function automatic int addr_bits(int row_bits, int col_bits);
    return row_lsb(col_bits) + row_bits;
  endfunction

  localparam int ADDRS = addr_bits(DEF_ROW_BITS, DEF_COL_BITS);

endpackage

// File: src/ddr3_req_decode.sv
`timescale 1ns/1ps

module ddr3_req_decode #(
  parameter int DDR_ROW_BITS = ddr3_geom_pkg::DEF_ROW_BITS,
  parameter int DDR_COL_BITS = ddr3_geom_pkg::DEF_COL_BITS,
  parameter int REQID = ddr3_geom_pkg::DEF_REQID
) (
  input  logic       clock_i,
  input  logic       reset_i,
  ddr3_req_if.decode rd_port,
  ddr3_req_if.decode wr_port,
  input  logic       busy_i,
  ddr3_sel_if.src    sel
);
  import ddr3_geom_pkg::*;

  localparam int ADDR_W = addr_bits(DDR_ROW_BITS, DDR_COL_BITS);
  localparam int BANK_LSB = bank_lsb(DDR_COL_BITS);
  localparam int ROW_LSB = row_lsb(DDR_COL_BITS);

  // port owning the burst, read when high
  logic              sel_rd_q;
  // cycle after a take, old beat still held until its ack
  logic              hold_q;
  logic              pick_rd;
  logic              req_w;
  logic              lst_w;
  logic [REQID-1:0]  tid_w;
  logic [ADDR_W-1:0] adr_w;

  // reads win unless a burst has locked the choice
  assign pick_rd = busy_i ? sel_rd_q : rd_port.req;

  assign req_w = pick_rd ? rd_port.req : wr_port.req;
  assign lst_w = pick_rd ? rd_port.lst : wr_port.lst;
  assign tid_w = pick_rd ? rd_port.tid : wr_port.tid;
  assign adr_w = pick_rd ? rd_port.adr : wr_port.adr;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      sel_rd_q <= 1'b0;
      hold_q   <= 1'b0;
    end else begin
      sel_rd_q <= pick_rd;
      hold_q   <= sel.take;
    end
  end

  // a consumed beat stays on the port until ack, so hide it for two cycles
  assign sel.valid = req_w & ~sel.take & ~hold_q;
  assign sel.is_rd = pick_rd;
  assign sel.lst   = lst_w;
  assign sel.tid   = tid_w;

  // address slicing, {row, bank, colhi}
  assign sel.row   = adr_w[ROW_LSB +: DDR_ROW_BITS];
  assign sel.bank  = adr_w[BANK_LSB +: BANK_BITS];
  assign sel.colhi = adr_w[BANK_LSB-1:0];

endmodule

// File: src/ddr3_req_if.sv
`timescale 1ns/1ps

// one request port, read or write
interface ddr3_req_if #(
  parameter int REQID = ddr3_geom_pkg::DEF_REQID,
  parameter int ADDRS = ddr3_geom_pkg::ADDRS
);

  // requester side, held stable until ack or err
  logic             req;
  // last beat of the burst
  logic             lst;
  logic [REQID-1:0] tid;
  logic [ADDRS-1:0] adr;

  // result side, single-cycle pulses
  logic             ack;
  logic             err;

  modport decode (
    input req,
    input lst,
    input tid,
    input adr
  );

  modport result (
    output ack,
    output err
  );

endinterface

// File: src/ddr3_resp_gen.sv
`timescale 1ns/1ps

module ddr3_resp_gen #(
  parameter int REQID = ddr3_geom_pkg::DEF_REQID
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             beat_i,
  input  logic             beat_rd_i,
  input  logic [REQID-1:0] beat_tid_i,
  input  logic             brk_i,
  ddr3_req_if.result       rd_port,
  ddr3_req_if.result       wr_port,
  output logic [REQID-1:0] rd_tid_o,
  output logic [REQID-1:0] wr_tid_o
);

  // burst owner, read port when high
  logic             own_rd_q;
  logic             rd_ack_q;
  logic             wr_ack_q;
  logic             rd_err_q;
  logic             wr_err_q;
  logic [REQID-1:0] rd_tid_q;
  logic [REQID-1:0] wr_tid_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      own_rd_q <= 1'b0;
      rd_ack_q <= 1'b0;
      wr_ack_q <= 1'b0;
      rd_err_q <= 1'b0;
      wr_err_q <= 1'b0;
    end else begin
      rd_ack_q <= beat_i & beat_rd_i;
      wr_ack_q <= beat_i & ~beat_rd_i;
      // a break always follows at least one beat of the same burst
      rd_err_q <= brk_i & own_rd_q;
      wr_err_q <= brk_i & ~own_rd_q;
      if (beat_i) begin
        own_rd_q <= beat_rd_i;
      end
    end
  end

  // id of the acknowledged beat, per port
  always_ff @(posedge clock) begin
    if (beat_i && beat_rd_i) begin
      rd_tid_q <= beat_tid_i;
    end
    if (beat_i && !beat_rd_i) begin
      wr_tid_q <= beat_tid_i;
    end
  end

  assign rd_port.ack = rd_ack_q;
  assign rd_port.err = rd_err_q;
  assign wr_port.ack = wr_ack_q;
  assign wr_port.err = wr_err_q;
  assign rd_tid_o    = rd_tid_q;
  assign wr_tid_o    = wr_tid_q;

endmodule

// File: src/ddr3_sel_if.sv
`timescale 1ns/1ps

// selected and sliced request, decode to execute
interface ddr3_sel_if #(
  parameter int DDR_ROW_BITS = ddr3_geom_pkg::DEF_ROW_BITS,
  parameter int DDR_COL_BITS = ddr3_geom_pkg::DEF_COL_BITS,
  parameter int REQID = ddr3_geom_pkg::DEF_REQID
);
  import ddr3_geom_pkg::*;

  logic                             valid;
  logic                             is_rd;
  logic                             lst;
  logic [REQID-1:0]                 tid;
  logic [BANK_BITS-1:0]             bank;
  logic [DDR_ROW_BITS-1:0]          row;
  logic [DDR_COL_BITS-BURST_BITS-1:0] colhi;
  // one-cycle pulse, current beat consumed
  logic                             take;

  modport src (output valid, is_rd, lst, tid, bank, row, colhi, input take);

  modport dst (input valid, is_rd, lst, tid, bank, row, colhi, output take);

endinterface

// File: tb/ddr3_dfi_model.sv
`timescale 1ns/1ps

module ddr3_dfi_model (
  input  logic                    clock_i,
  input  logic                    reset_i,
  input  logic                    ddl_req_i,
  input  ddr3_cmd_pkg::ddr3_cmd_t ddl_cmd_i,
  input  logic                    ref_go_i,
  output logic                    ddl_rdy_o,
  output logic                    ddl_ref_o
);
  import ddr3_cmd_pkg::*;

  int   seed = 54546;
  int   refr_cnt = 0;
  int   refr_base = 0;
  int   hold = 0;
  logic go_q = 1'b0;

  initial begin
    ddl_rdy_o = 1'b1;
    ddl_ref_o = 1'b0;
  end

  // count accepted refreshes, sample the test's refresh trigger
  always @(posedge clock_i) begin
    go_q <= ref_go_i;
    if (ddl_req_i && ddl_rdy_o && ddl_cmd_i == CMD_REFR) begin
      refr_cnt <= refr_cnt + 1;
    end
  end

  always @(negedge clock_i) begin
    // always ready in reset so config commands go straight through
    ddl_rdy_o <= reset_i ? 1'b1 : (($random(seed) & 3) != 0);
    if (go_q && !ddl_ref_o) begin
      ddl_ref_o <= 1'b1;
      refr_base = refr_cnt;
      hold = 0;
    end else if (ddl_ref_o && refr_cnt != refr_base) begin
      // keep the request up a while after the refresh was taken
      hold = hold + 1;
      if (hold >= 8) begin
        ddl_ref_o <= 1'b0;
      end
    end
  end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clock_o,
  output logic reset_o
);

  initial clock_o = 1'b0;
  always #(PERIOD / 2) clock_o = ~clock_o;

  // reset held over the first rising edges, released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;
  end

endmodule

// File: tb/tb_ddr3_cmd.sv
`timescale 1ns/1ps

module tb_ddr3_cmd;
  import ddr3_cmd_pkg::*;
  import ddr3_geom_pkg::*;

  localparam int ROW_W = DEF_ROW_BITS;
  localparam int COLHI_W = DEF_COL_BITS - BURST_BITS;
  localparam int ADDR_W = ADDRS;
  localparam int NUM_TESTS = 6;

  typedef struct packed {
    ddr3_cmd_t            cmd;
    logic                 seq;
    logic [BANK_BITS-1:0] ba;
    logic [ROW_W-1:0]     adr;
  } cmd_rec_t;

  logic clock;
  logic reset;
  logic mem_wrreq, mem_wrlst, mem_wrack, mem_wrerr;
  logic mem_rdreq, mem_rdlst, mem_rdack, mem_rderr;
  logic [DEF_REQID-1:0] mem_wrtid, mem_rdtid, mem_wrtid_o, mem_rdtid_o;
  logic [ADDR_W-1:0] mem_wradr, mem_rdadr;
  logic cfg_req, cfg_rdy;
  ddr3_cmd_t cfg_cmd;
  logic [BANK_BITS-1:0] cfg_ba;
  logic [ROW_W-1:0] cfg_adr;
  logic ddl_req, ddl_seq, ddl_rdy, ddl_ref, ref_go;
  ddr3_cmd_t ddl_cmd;
  logic [BANK_BITS-1:0] ddl_ba;
  logic [ROW_W-1:0] ddl_adr;

  cmd_rec_t exp_q[$];
  logic     ack_log[$];
  int errors = 0;
  int failed_tests = 0;
  int rd_errs = 0;
  int wr_errs = 0;

  tb_clock #(.PERIOD(20), .RESET_CYCLES(4)) clk_gen (.clock_o(clock), .reset_o(reset));

  ddr3_dfi_model dfi (
    .clock_i(clock), .reset_i(reset), .ddl_req_i(ddl_req), .ddl_cmd_i(ddl_cmd),
    .ref_go_i(ref_go), .ddl_rdy_o(ddl_rdy), .ddl_ref_o(ddl_ref)
  );

  ddr3_cmd_top ddr3_cmd_top_inst (
    .clock(clock), .reset(reset),
    .mem_wrreq_i(mem_wrreq), .mem_wrlst_i(mem_wrlst), .mem_wrtid_i(mem_wrtid),
    .mem_wradr_i(mem_wradr), .mem_wrack_o(mem_wrack), .mem_wrerr_o(mem_wrerr),
    .mem_wrtid_o(mem_wrtid_o),
    .mem_rdreq_i(mem_rdreq), .mem_rdlst_i(mem_rdlst), .mem_rdtid_i(mem_rdtid),
    .mem_rdadr_i(mem_rdadr), .mem_rdack_o(mem_rdack), .mem_rderr_o(mem_rderr),
    .mem_rdtid_o(mem_rdtid_o),
    .cfg_req_i(cfg_req), .cfg_rdy_o(cfg_rdy), .cfg_cmd_i(cfg_cmd), .cfg_ba_i(cfg_ba),
    .cfg_adr_i(cfg_adr),
    .ddl_req_o(ddl_req), .ddl_seq_o(ddl_seq), .ddl_cmd_o(ddl_cmd), .ddl_ba_o(ddl_ba),
    .ddl_adr_o(ddl_adr), .ddl_rdy_i(ddl_rdy), .ddl_ref_i(ddl_ref)
  );

  // expand one request into the accepted command stream it should give
  function automatic void expected_cmds(input logic is_rd, input logic [ADDR_W-1:0] base,
                                        input int beats, input logic broken);
    cmd_rec_t r;
    logic [ADDR_W-1:0] a;
    r.cmd = CMD_ACTV;
    r.seq = 1'b1;
    r.ba  = base[COLHI_W +: BANK_BITS];
    r.adr = base[COLHI_W + BANK_BITS +: ROW_W];
    exp_q.push_back(r);
    for (int i = 0; i < beats; i++) begin
      a = base + ADDR_W'(i);
      r.cmd = is_rd ? CMD_READ : CMD_WRIT;
      r.adr = '0;
      r.adr[DEF_COL_BITS-1:BURST_BITS] = a[COLHI_W-1:0];
      // auto-precharge only on a real last beat
      r.adr[AP_BIT] = (i == beats - 1) && !broken;
      // another command follows unless this beat ends the burst
      r.seq = !((i == beats - 1) && !broken);
      exp_q.push_back(r);
    end
    if (broken) begin
      r.cmd = CMD_PREC;
      r.seq = 1'b0;
      r.adr = '0;
      exp_q.push_back(r);
    end
  endfunction

  function automatic void expect_one(input ddr3_cmd_t cmd, input logic [BANK_BITS-1:0] ba,
                                     input logic [ROW_W-1:0] adr);
    cmd_rec_t r;
    r.cmd = cmd;
    // config and refresh commands stand alone
    r.seq = 1'b0;
    r.ba  = ba;
    r.adr = adr;
    exp_q.push_back(r);
  endfunction

  // accepted command is req and rdy high together at a rising edge
  always @(posedge clock) begin : monitor
    cmd_rec_t e;
    if (ddl_req && ddl_rdy) begin
      if (exp_q.size() == 0) begin
        $display("%0t: data layer accepted %s but no command was expected", $time,
                 ddl_cmd.name());
        errors++;
      end else begin
        e = exp_q.pop_front();
        assert (ddl_cmd == e.cmd) else begin
          $display("[FAIL] %0t ddl_cmd_o expected %s got %s", $time, e.cmd.name(),
                   ddl_cmd.name());
          errors++;
        end
        assert (ddl_seq == e.seq) else begin
          $display("[FAIL] %0t ddl_seq_o expected %0b got %0b", $time, e.seq, ddl_seq);
          errors++;
        end
        assert (ddl_ba == e.ba) else begin
          $display("[FAIL] %0t ddl_ba_o expected %0h got %0h", $time, e.ba, ddl_ba);
          errors++;
        end
        assert (ddl_adr == e.adr) else begin
          $display("[FAIL] %0t ddl_adr_o expected %0h got %0h", $time, e.adr, ddl_adr);
          errors++;
        end
      end
      assert (!(ddl_cmd == CMD_ACTV && ddl_ref)) else begin
        $display("%0t: activate accepted while refresh still requested", $time);
        errors++;
      end
    end
    // config ready mirrors the data layer's ready
    assert (cfg_rdy == ddl_rdy) else begin
      $display("[FAIL] %0t cfg_rdy_o expected %0b got %0b", $time, ddl_rdy, cfg_rdy);
      errors++;
    end
  end

  always @(negedge clock) begin
    if (!reset) begin
      if (mem_rderr) rd_errs++;
      if (mem_wrerr) wr_errs++;
    end
  end

  task automatic drive_port(input logic is_rd, input logic req, input logic lst,
                            input logic [DEF_REQID-1:0] tid, input logic [ADDR_W-1:0] adr);
    if (is_rd) begin
      mem_rdreq = req;
      mem_rdlst = lst;
      mem_rdtid = tid;
      mem_rdadr = adr;
    end else begin
      mem_wrreq = req;
      mem_wrlst = lst;
      mem_wrtid = tid;
      mem_wradr = adr;
    end
  endtask

  // drives one beat at a time from a falling edge and waits for each ack
  task automatic run_burst(input logic is_rd, input logic [ADDR_W-1:0] base,
                           input logic [DEF_REQID-1:0] tid0, input int beats,
                           input logic broken);
    logic [DEF_REQID-1:0] tid;
    logic [DEF_REQID-1:0] got;
    for (int i = 0; i < beats; i++) begin
      tid = tid0 + DEF_REQID'(i);
      drive_port(is_rd, 1'b1, (i == beats - 1) && !broken, tid, base + ADDR_W'(i));
      do @(negedge clock); while (!(is_rd ? mem_rdack : mem_wrack));
      got = is_rd ? mem_rdtid_o : mem_wrtid_o;
      ack_log.push_back(is_rd);
      assert (got == tid) else begin
        $display("[FAIL] %0t %s expected %0h got %0h", $time,
                 is_rd ? "mem_rdtid_o" : "mem_wrtid_o", tid, got);
        errors++;
      end
    end
    drive_port(is_rd, 1'b0, 1'b0, '0, '0);
    if (broken) begin
      do @(negedge clock); while (!(is_rd ? mem_rderr : mem_wrerr));
    end
  endtask

  task automatic finish_test(input int num, input string name, input int err_start);
    while (exp_q.size() != 0) @(negedge clock);
    repeat (6) @(negedge clock);
    if (errors == err_start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: FAILED with %0d errors", num, name, errors - err_start);
      failed_tests++;
    end
  endtask

  initial begin : stimulus
    int e0;
    drive_port(1'b1, 1'b0, 1'b0, '0, '0);
    drive_port(1'b0, 1'b0, 1'b0, '0, '0);
    ref_go = 1'b0;
    // test 1 forwards config while reset is high
    e0 = errors;
    cfg_req = 1'b1;
    cfg_cmd = CMD_MODE;
    cfg_ba  = 3'd2;
    cfg_adr = 13'h0520;
    expect_one(CMD_MODE, 3'd2, 13'h0520);
    expect_one(CMD_ZQCL, 3'd0, 13'h0400);
    @(negedge clock);
    cfg_cmd = CMD_ZQCL;
    cfg_ba  = 3'd0;
    cfg_adr = 13'h0400;
    @(negedge clock);
    cfg_req = 1'b0;
    cfg_cmd = CMD_NOOP;
    while (reset) @(negedge clock);
    finish_test(1, "config forwarding", e0);

    e0 = errors;
    expected_cmds(1'b1, {13'h0123, 3'd5, 7'h10}, 1, 1'b0);
    run_burst(1'b1, {13'h0123, 3'd5, 7'h10}, 4'h3, 1, 1'b0);
    finish_test(2, "single-beat read", e0);

    e0 = errors;
    expected_cmds(1'b0, {13'h0abc, 3'd2, 7'h20}, 4, 1'b0);
    run_burst(1'b0, {13'h0abc, 3'd2, 7'h20}, 4'h8, 4, 1'b0);
    finish_test(3, "four-beat write", e0);

    // read and write raised together so the read goes first
    e0 = errors;
    ack_log.delete();
    expected_cmds(1'b1, {13'h1f00, 3'd7, 7'h04}, 1, 1'b0);
    expected_cmds(1'b0, {13'h0042, 3'd1, 7'h30}, 2, 1'b0);
    fork
      run_burst(1'b1, {13'h1f00, 3'd7, 7'h04}, 4'h1, 1, 1'b0);
      run_burst(1'b0, {13'h0042, 3'd1, 7'h30}, 4'h6, 2, 1'b0);
    join
    assert (ack_log.size() == 3 && ack_log[0] == 1'b1) else begin
      $display("%0t: write port acknowledged before the read port", $time);
      errors++;
    end
    finish_test(4, "arbitration", e0);

    e0 = errors;
    expect_one(CMD_REFR, 3'd0, 13'h0000);
    expected_cmds(1'b1, {13'h0777, 3'd3, 7'h11}, 1, 1'b0);
    ref_go = 1'b1;
    @(negedge clock);
    ref_go = 1'b0;
    @(negedge clock);
    run_burst(1'b1, {13'h0777, 3'd3, 7'h11}, 4'h9, 1, 1'b0);
    finish_test(5, "refresh", e0);

    // write abandoned after its first beat
    e0 = errors;
    expected_cmds(1'b0, {13'h0305, 3'd6, 7'h08}, 1, 1'b1);
    run_burst(1'b0, {13'h0305, 3'd6, 7'h08}, 4'hc, 1, 1'b1);
    finish_test(6, "broken burst", e0);
    assert (wr_errs == 1 && rd_errs == 0) else begin
      $display("[FAIL] %0t mem_wrerr_o expected 1 pulse got %0d, mem_rderr_o got %0d",
               $time, wr_errs, rd_errs);
      errors++;
    end

    $display("tests %0d, failed tests %0d, errors %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // each test gets at most 400 clock cycles
  initial begin : watchdog
    #(NUM_TESTS * 400 * 20);
    $display("timeout, the tests did not finish within %0d cycles", NUM_TESTS * 400);
    $display("Regression failed");
    $finish;
  end

endmodule
